//--- source/bp_pkg.sv
package bp_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // field widths
    // ~~~~~~~~~~~~~~~~~~~~

    // one index per projection angle
    localparam int angle_w = 9;
    // detector positions within one projection
    localparam int s_w = 8;
    // raw sample straight out of the projection RAM
    localparam int raw_w = 12;
    // filtered sample, signed after the high-pass
    localparam int fval_w = 16;

    // ~~~~~~~~~~~~~~~~~~~~
    // scalar types
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic [angle_w-1:0] angle_t;
    typedef logic [s_w-1:0] s_t;
    typedef logic [raw_w-1:0] raw_t;
    typedef logic signed [fval_w-1:0] fval_t;

    // rotation selector, only 0..2 are legal
    typedef logic [1:0] rot_sel_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // angle tag
    // ~~~~~~~~~~~~~~~~~~~~

    // rides along with each buffer role through the rotation
    // valid low means the buffer holds no real angle
    typedef struct packed
    {
        logic valid;
        angle_t angle;
    } angle_tag_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // swap sequencer states
    // ~~~~~~~~~~~~~~~~~~~~

    // ready: all idle, waiting for first host angle
    // fill: first angle loading, nothing to read yet
    // fill_and_work*: one buffer loading while two are read
    // work_1, work_2: draining, no more host angles
    typedef enum logic [2:0]
    {
        ready,
        fill,
        fill_and_work,
        fill_and_work_repeat,
        work_1,
        work_2
    } swap_state_t;

endpackage

//--- source/fir_filter.sv
module fir_filter
(
    input logic clk,
    input logic reset_n,
    input bp_pkg::raw_t hs_raw,
    output bp_pkg::fval_t hs_val
);

    // accumulator wide enough that saturation is a pure range check
    localparam int acc_w = $bits(bp_pkg::fval_t) + 2;
    typedef logic signed [acc_w-1:0] acc_t;

    // signed limits of the output type
    localparam acc_t sat_hi = (acc_t'(1) <<< ($bits(bp_pkg::fval_t) - 1)) - acc_t'(1);
    localparam acc_t sat_lo = -(acc_t'(1) <<< ($bits(bp_pkg::fval_t) - 1));

    // x(k-1), x(k-2)
    bp_pkg::raw_t x1;
    bp_pkg::raw_t x2;
    acc_t acc_next;
    acc_t acc;

    // taps 2, -1, -1
    // raw is unsigned so the casts zero extend
    always_comb
    begin
        acc_next = (acc_t'(hs_raw) <<< 1) - acc_t'(x1) - acc_t'(x2);
    end

    // stage 1: history and raw sum
    // stage 2: clamp into fval_t
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            x1 <= '0;
            x2 <= '0;
            acc <= '0;
            hs_val <= '0;
        end
        else
        begin
            x1 <= hs_raw;
            x2 <= x1;
            acc <= acc_next;
            if (acc > sat_hi)
                hs_val <= bp_pkg::fval_t'(sat_hi);
            else if (acc < sat_lo)
                hs_val <= bp_pkg::fval_t'(sat_lo);
            else
                hs_val <= bp_pkg::fval_t'(acc);
        end
    end

endmodule

//--- source/filtered_ram_swappable.sv
module filtered_ram_swappable
#(
    parameter int fill_length = 256,
    parameter int fill_delay = 3
)
(
    input logic clk,
    input logic reset_n,
    input logic fill_kick,
    input bp_pkg::fval_t hs_val,
    input bp_pkg::s_t rd0_s,
    input bp_pkg::s_t rd1_s,
    output logic fill_done,
    output bp_pkg::s_t hs_s_val,
    output bp_pkg::fval_t rd0_val,
    output bp_pkg::fval_t rd1_val
);

    // address in flight towards the RAM and filter
    typedef struct packed
    {
        logic valid;
        bp_pkg::s_t s;
    } tap_t;

    localparam bp_pkg::s_t last_s = bp_pkg::s_t'(fill_length - 1);

    bp_pkg::fval_t mem [fill_length];
    logic fetching;
    bp_pkg::s_t fetch_s;
    tap_t tap [fill_delay];
    tap_t wr;

    // ~~~~~~~~~~~~~~~~~~~~
    // fetch side
    // ~~~~~~~~~~~~~~~~~~~~

    // walk 0 .. fill_length-1 once per kick
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            fetching <= 1'b0;
            fetch_s <= '0;
        end
        else if (fill_kick)
        begin
            fetching <= 1'b1;
            fetch_s <= '0;
        end
        else if (fetching)
        begin
            if (fetch_s == last_s)
            begin
                fetching <= 1'b0;
                fetch_s <= '0;
            end
            else
                fetch_s <= fetch_s + 1'b1;
        end
    end

    // idle buffer parks the RAM on address 0
    assign hs_s_val = fetching ? fetch_s : '0;

    // ~~~~~~~~~~~~~~~~~~~~
    // write side
    // ~~~~~~~~~~~~~~~~~~~~

    // RAM read plus filter latency, matched here
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            for (int i = 0; i < fill_delay; i++)
                tap[i].valid <= 1'b0;
        end
        else
        begin
            tap[0] <= '{valid: fetching, s: fetch_s};
            for (int i = 1; i < fill_delay; i++)
                tap[i] <= tap[i-1];
        end
    end

    assign wr = tap[fill_delay-1];

    // done once the last address has landed
    always_ff @(posedge clk)
    begin
        if (reset_n)
            fill_done <= 1'b1;
        else if (fill_kick)
            fill_done <= 1'b0;
        else if (wr.valid && wr.s == last_s)
            fill_done <= 1'b1;
    end

    // one write port, two registered read ports
    always_ff @(posedge clk)
    begin
        if (wr.valid)
            mem[wr.s] <= hs_val;
        rd0_val <= mem[rd0_s];
        rd1_val <= mem[rd1_s];
    end

    // kicks only land on an idle, complete buffer
    kick_when_idle: assert property (@(posedge clk) disable iff (reset_n)
        fill_kick |-> fill_done);

    // a kick finishes in exactly fill_length + fill_delay cycles
    fill_latency: assert property (@(posedge clk) disable iff (reset_n)
        fill_kick |=> !fill_done [*fill_length + fill_delay] ##1 fill_done);

endmodule

//--- source/swap_sequencer.sv
module swap_sequencer
(
    input logic clk,
    input logic reset_n,
    input logic hs_has_next_angle,
    input logic hs_next_angle_ack,
    input logic pr_next_angle,
    input logic pr_done,
    input logic fill_done,
    output logic rotate,
    output logic hs_next_angle,
    output logic pr_next_angle_ack
);

    bp_pkg::swap_state_t state;
    bp_pkg::swap_state_t next_state;

    always_ff @(posedge clk)
    begin
        if (reset_n)
            state <= bp_pkg::ready;
        else
            state <= next_state;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // mealy outputs
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        rotate = 1'b0;
        hs_next_angle = 1'b0;
        case (state)
            // first angle accepted straight away
            bp_pkg::ready:
                if (hs_next_angle_ack)
                    rotate = 1'b1;
            // ask for the next angle once loaded
            bp_pkg::fill:
                if (fill_done)
                begin
                    hs_next_angle = 1'b1;
                    if (hs_next_angle_ack)
                        rotate = 1'b1;
                end
            // need both loader and consumers ready
            // host out of angles means rotate without waiting for it
            bp_pkg::fill_and_work, bp_pkg::fill_and_work_repeat:
                if (fill_done && pr_next_angle)
                begin
                    hs_next_angle = hs_has_next_angle;
                    if (hs_next_angle_ack || !hs_has_next_angle)
                        rotate = 1'b1;
                end
            // drain, consumers only
            bp_pkg::work_1:
                if (pr_next_angle)
                    rotate = 1'b1;
            default:
                rotate = 1'b0;
        endcase
    end

    // consumers see the swap as their ack
    assign pr_next_angle_ack = rotate;

    // ~~~~~~~~~~~~~~~~~~~~
    // next state
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        next_state = state;
        case (state)
            bp_pkg::ready:
                if (rotate)
                    next_state = bp_pkg::fill;
            bp_pkg::fill:
                if (rotate)
                    next_state = bp_pkg::fill_and_work;
            bp_pkg::fill_and_work:
                if (rotate)
                    next_state = bp_pkg::fill_and_work_repeat;
            // loop while the host keeps supplying angles
            bp_pkg::fill_and_work_repeat:
                if (rotate && !hs_has_next_angle)
                    next_state = bp_pkg::work_1;
            bp_pkg::work_1:
                if (rotate)
                    next_state = bp_pkg::work_2;
            // last angle being read, wait for consumers
            bp_pkg::work_2:
                if (pr_done)
                    next_state = bp_pkg::ready;
            default:
                next_state = bp_pkg::ready;
        endcase
    end

    state_legal: assert property (@(posedge clk) disable iff (reset_n)
        state inside {bp_pkg::ready, bp_pkg::fill, bp_pkg::fill_and_work,
                      bp_pkg::fill_and_work_repeat, bp_pkg::work_1, bp_pkg::work_2});

    no_rotate_draining: assert property (@(posedge clk) disable iff (reset_n)
        state == bp_pkg::work_2 |-> !rotate);

endmodule

//--- source/swap_router.sv
module swap_router
(
    input logic clk,
    input logic reset_n,
    input logic rotate,
    input bp_pkg::angle_t hs_angle,
    input logic hs_has_next_angle,
    input bp_pkg::s_t pr0_s_val,
    input bp_pkg::s_t pr1_s_val,
    // per buffer
    output logic [2:0] sw_fill_kick,
    output bp_pkg::s_t sw_rd_s [3][2],
    input bp_pkg::fval_t sw_rd_val [3][2],
    input bp_pkg::s_t sw_hs_s_val [3],
    input logic [2:0] sw_fill_done,
    // outside
    output bp_pkg::s_t hs_s_val,
    output logic fill_done,
    output bp_pkg::fval_t pr0_val,
    output bp_pkg::fval_t pr1_val,
    output bp_pkg::angle_tag_t pr0_tag,
    output bp_pkg::angle_tag_t pr1_tag
);

    // buffer index per role
    typedef struct packed
    {
        logic [1:0] fill;
        logic [1:0] p0;
        logic [1:0] p1;
    } roles_t;

    // rot_sel | fill p0 p1
    //    0    |  0   1  2
    //    1    |  2   0  1
    //    2    |  1   2  0
    function automatic roles_t roles_of(input bp_pkg::rot_sel_t sel);
        roles_t r;
        case (sel)
            2'd0: r = '{fill: 2'd0, p0: 2'd1, p1: 2'd2};
            2'd1: r = '{fill: 2'd2, p0: 2'd0, p1: 2'd1};
            default: r = '{fill: 2'd1, p0: 2'd2, p1: 2'd0};
        endcase
        return r;
    endfunction

    bp_pkg::rot_sel_t rot_sel;
    // role at the address cycle, for returning read data
    bp_pkg::rot_sel_t rot_sel_d;
    bp_pkg::angle_tag_t slot;
    roles_t now_r;
    roles_t rd_r;

    // ~~~~~~~~~~~~~~~~~~~~
    // rotation state
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            rot_sel <= 2'd0;
            rot_sel_d <= 2'd0;
        end
        else
        begin
            rot_sel_d <= rot_sel;
            if (rotate)
                rot_sel <= (rot_sel == 2'd2) ? 2'd0 : rot_sel + 2'd1;
        end
    end

    // tag pipeline, slot -> port 0 -> port 1
    // slot covers the angle still loading
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            slot.valid <= 1'b0;
            pr0_tag.valid <= 1'b0;
            pr1_tag.valid <= 1'b0;
        end
        else if (rotate)
        begin
            slot <= '{valid: hs_has_next_angle, angle: hs_angle};
            pr0_tag <= slot;
            pr1_tag <= pr0_tag;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // steering
    // ~~~~~~~~~~~~~~~~~~~~

    assign now_r = roles_of(rot_sel);
    assign rd_r = roles_of(rot_sel_d);

    // host side follows the loading buffer
    assign hs_s_val = sw_hs_s_val[now_r.fill];
    assign fill_done = sw_fill_done[now_r.fill];

    // port 0 buffer read on its rd0, port 1 buffer on its rd1
    // kick the port 1 buffer, it turns into the loader after the swap
    always_comb
    begin
        for (int i = 0; i < 3; i++)
        begin
            sw_fill_kick[i] = rotate && (now_r.p1 == 2'(i));
            sw_rd_s[i][0] = (now_r.p0 == 2'(i)) ? pr0_s_val : '0;
            sw_rd_s[i][1] = (now_r.p1 == 2'(i)) ? pr1_s_val : '0;
        end
    end

    assign pr0_val = sw_rd_val[rd_r.p0][0];
    assign pr1_val = sw_rd_val[rd_r.p1][1];

    rot_sel_legal: assert property (@(posedge clk) disable iff (reset_n)
        rot_sel != 2'd3);

    single_kick: assert property (@(posedge clk) disable iff (reset_n)
        $onehot0(sw_fill_kick));

endmodule

//--- source/filtered_ram_subsystem.sv
module filtered_ram_subsystem
#(
    parameter int fill_length = 256,
    parameter int fill_delay = 3
)
(
    input logic clk,
    input logic reset_n,
    // host
    input bp_pkg::angle_t hs_angle,
    input logic hs_has_next_angle,
    input logic hs_next_angle_ack,
    input bp_pkg::raw_t hs_raw,
    output bp_pkg::s_t hs_s_val,
    output logic hs_next_angle,
    // consumers
    input bp_pkg::s_t pr0_s_val,
    input bp_pkg::s_t pr1_s_val,
    input logic pr_next_angle,
    input logic pr_done,
    output bp_pkg::angle_tag_t pr0_tag,
    output bp_pkg::angle_tag_t pr1_tag,
    output logic pr_next_angle_ack,
    output bp_pkg::fval_t pr0_val,
    output bp_pkg::fval_t pr1_val
);

    // filtered stream, shared by all buffers
    wire bp_pkg::fval_t hs_val;
    wire rotate;
    wire fill_done;
    // per buffer links to the router
    wire [2:0] sw_fill_kick;
    wire [2:0] sw_fill_done;
    wire bp_pkg::s_t sw_hs_s_val [3];
    wire bp_pkg::s_t sw_rd_s [3][2];
    wire bp_pkg::fval_t sw_rd_val [3][2];

    fir_filter u_fir
    (
        .clk(clk),
        .reset_n(reset_n),
        .hs_raw(hs_raw),
        .hs_val(hs_val)
    );

    swap_sequencer u_seq
    (
        .clk(clk),
        .reset_n(reset_n),
        .hs_has_next_angle(hs_has_next_angle),
        .hs_next_angle_ack(hs_next_angle_ack),
        .pr_next_angle(pr_next_angle),
        .pr_done(pr_done),
        .fill_done(fill_done),
        .rotate(rotate),
        .hs_next_angle(hs_next_angle),
        .pr_next_angle_ack(pr_next_angle_ack)
    );

    swap_router u_router
    (
        .clk(clk),
        .reset_n(reset_n),
        .rotate(rotate),
        .hs_angle(hs_angle),
        .hs_has_next_angle(hs_has_next_angle),
        .pr0_s_val(pr0_s_val),
        .pr1_s_val(pr1_s_val),
        .sw_fill_kick(sw_fill_kick),
        .sw_rd_s(sw_rd_s),
        .sw_rd_val(sw_rd_val),
        .sw_hs_s_val(sw_hs_s_val),
        .sw_fill_done(sw_fill_done),
        .hs_s_val(hs_s_val),
        .fill_done(fill_done),
        .pr0_val(pr0_val),
        .pr1_val(pr1_val),
        .pr0_tag(pr0_tag),
        .pr1_tag(pr1_tag)
    );

    // three rotating buffers
    for (genvar i = 0; i < 3; i++)
    begin : g_buf
        filtered_ram_swappable
        #(
            .fill_length(fill_length),
            .fill_delay(fill_delay)
        )
        u_buf
        (
            .clk(clk),
            .reset_n(reset_n),
            .fill_kick(sw_fill_kick[i]),
            .hs_val(hs_val),
            .rd0_s(sw_rd_s[i][0]),
            .rd1_s(sw_rd_s[i][1]),
            .fill_done(sw_fill_done[i]),
            .hs_s_val(sw_hs_s_val[i]),
            .rd0_val(sw_rd_val[i][0]),
            .rd1_val(sw_rd_val[i][1])
        );
    end

endmodule

//--- sim/tb_filtered_ram.sv
module tb_filtered_ram;

    localparam int fill_length = 256;
    localparam int fill_delay = 3;
    localparam int period = 4;
    // slack per angle for ack delays, reads and idle gaps
    localparam int margin = 300;
    // angles moved through the DUT over all tests, rounded up
    localparam int angle_budget = 16;
    localparam int wait_limit = 2 * (fill_length + fill_delay) + 64;

    logic clk;
    logic reset_n;
    bp_pkg::angle_t hs_angle;
    logic hs_has_next_angle;
    logic hs_next_angle_ack;
    bp_pkg::raw_t hs_raw;
    bp_pkg::s_t hs_s_val;
    logic hs_next_angle;
    bp_pkg::s_t pr0_s_val;
    bp_pkg::s_t pr1_s_val;
    logic pr_next_angle;
    logic pr_done;
    bp_pkg::angle_tag_t pr0_tag;
    bp_pkg::angle_tag_t pr1_tag;
    logic pr_next_angle_ack;
    bp_pkg::fval_t pr0_val;
    bp_pkg::fval_t pr1_val;

    // expected tag pipeline, slot -> port 0 -> port 1
    bp_pkg::angle_tag_t exp_slot;
    bp_pkg::angle_tag_t exp_pr0;
    bp_pkg::angle_tag_t exp_pr1;
    int errors;
    int tests;
    int failed_tests;
    int ack_count;
    int rng_init;

    filtered_ram_subsystem
    #(
        .fill_length(fill_length),
        .fill_delay(fill_delay)
    )
    uut
    (
        .clk(clk),
        .reset_n(reset_n),
        .hs_angle(hs_angle),
        .hs_has_next_angle(hs_has_next_angle),
        .hs_next_angle_ack(hs_next_angle_ack),
        .hs_raw(hs_raw),
        .hs_s_val(hs_s_val),
        .hs_next_angle(hs_next_angle),
        .pr0_s_val(pr0_s_val),
        .pr1_s_val(pr1_s_val),
        .pr_next_angle(pr_next_angle),
        .pr_done(pr_done),
        .pr0_tag(pr0_tag),
        .pr1_tag(pr1_tag),
        .pr_next_angle_ack(pr_next_angle_ack),
        .pr0_val(pr0_val),
        .pr1_val(pr1_val)
    );

    initial
    begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // projection RAM and reference
    // ~~~~~~~~~~~~~~~~~~~~

    // fixed hash of angle and address
    function automatic bp_pkg::raw_t raw_of(input bp_pkg::angle_t a, input bp_pkg::s_t s);
        int h;
        h = int'(a) * 97 + int'(s) * 31 + (int'(a) ^ int'(s)) * 13 + int'(s) * int'(s) * 7;
        return bp_pkg::raw_t'(h ^ (h >> 5));
    endfunction

    // below address 0 the idle RAM still shows address 0
    function automatic int raw_at(input bp_pkg::angle_t a, input int j);
        if (j < 0)
            return int'(raw_of(a, '0));
        return int'(raw_of(a, bp_pkg::s_t'(j)));
    endfunction

    // taps 2, -1, -1 then clamp to 16 bit signed
    function automatic bp_pkg::fval_t filt_of(input bp_pkg::angle_t a, input int k);
        int v;
        v = 2 * raw_at(a, k) - raw_at(a, k - 1) - raw_at(a, k - 2);
        if (v > 32767)
            v = 32767;
        else if (v < -32768)
            v = -32768;
        return bp_pkg::fval_t'(v);
    endfunction

    // one cycle registered read
    always @(posedge clk)
    begin
        hs_raw <= raw_of(hs_angle, hs_s_val);
    end

    // ack pulses, value of the cycle just ending
    always @(posedge clk)
    begin
        if (!reset_n && pr_next_angle_ack)
            ack_count <= ack_count + 1;
    end

    initial
    begin
        #(angle_budget * (fill_length + fill_delay + margin) * period);
        $display("watchdog expired, run took longer than %0d angle budgets", angle_budget);
        $display("Simulation failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // handshake helpers
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic close_test(input string name, input int err_start);
        tests++;
        if (errors == err_start)
            $display("test %s: ok", name);
        else
        begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    task automatic check_tags();
        if (pr0_tag.valid !== exp_pr0.valid ||
            (exp_pr0.valid && pr0_tag.angle !== exp_pr0.angle))
        begin
            $display("ERROR pr0_tag got %h expected %h", pr0_tag, exp_pr0);
            errors++;
        end
        if (pr1_tag.valid !== exp_pr1.valid ||
            (exp_pr1.valid && pr1_tag.angle !== exp_pr1.angle))
        begin
            $display("ERROR pr1_tag got %h expected %h", pr1_tag, exp_pr1);
            errors++;
        end
    endtask

    task automatic wait_request();
        int n;
        n = 0;
        @(negedge clk);
        while (!hs_next_angle && n < wait_limit)
        begin
            @(negedge clk);
            n++;
        end
        if (!hs_next_angle)
        begin
            $display("hs_next_angle did not rise within %0d cycles", wait_limit);
            errors++;
        end
    endtask

    // swap seen at a negedge takes effect at the next posedge
    task automatic wait_rotate();
        int n;
        n = 0;
        @(negedge clk);
        while (!pr_next_angle_ack && n < wait_limit)
        begin
            @(negedge clk);
            n++;
        end
        if (!pr_next_angle_ack)
        begin
            $display("no pr_next_angle_ack within %0d cycles", wait_limit);
            errors++;
        end
        else
        begin
            exp_pr1 = exp_pr0;
            exp_pr0 = exp_slot;
            exp_slot = '{valid: hs_has_next_angle, angle: hs_angle};
        end
        @(posedge clk);
        hs_next_angle_ack <= 1'b0;
        pr_next_angle <= 1'b0;
        @(negedge clk);
        check_tags();
    endtask

    // RAM must show the new angle on address 0 for two edges before the kick
    task automatic present_angle(input bp_pkg::angle_t a);
        @(posedge clk);
        hs_angle <= a;
        hs_has_next_angle <= 1'b1;
        repeat (2 + $urandom % 4) @(posedge clk);
    endtask

    task automatic host_step(input bp_pkg::angle_t a);
        present_angle(a);
        hs_next_angle_ack <= 1'b1;
        wait_rotate();
    endtask

    // consumers done, host supplies the next angle
    task automatic advance(input bp_pkg::angle_t a);
        @(posedge clk);
        pr_next_angle <= 1'b1;
        wait_request();
        host_step(a);
    endtask

    task automatic read_pair(input bp_pkg::s_t a, input bp_pkg::s_t b,
                             output bp_pkg::fval_t got0, output bp_pkg::fval_t got1);
        @(posedge clk);
        pr0_s_val <= a;
        pr1_s_val <= b;
        @(posedge clk);
        @(negedge clk);
        got0 = pr0_val;
        got1 = pr1_val;
        // invalid tag means no angle behind the port
        if (exp_pr0.valid && pr0_val !== filt_of(exp_pr0.angle, int'(a)))
        begin
            $display("ERROR pr0_val got %h expected %h", pr0_val, filt_of(exp_pr0.angle, int'(a)));
            errors++;
        end
        if (exp_pr1.valid && pr1_val !== filt_of(exp_pr1.angle, int'(b)))
        begin
            $display("ERROR pr1_val got %h expected %h", pr1_val, filt_of(exp_pr1.angle, int'(b)));
            errors++;
        end
    endtask

    task automatic read_check(input int n);
        bp_pkg::fval_t g0;
        bp_pkg::fval_t g1;
        for (int i = 0; i < n; i++)
            read_pair(bp_pkg::s_t'($urandom % fill_length),
                      bp_pkg::s_t'($urandom % fill_length), g0, g1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic test_reset();
        int e;
        int acks;
        e = errors;
        @(negedge clk);
        if (hs_next_angle !== 1'b0)
        begin
            $display("ERROR hs_next_angle got %h expected 0", hs_next_angle);
            errors++;
        end
        if (pr_next_angle_ack !== 1'b0)
        begin
            $display("ERROR pr_next_angle_ack got %h expected 0", pr_next_angle_ack);
            errors++;
        end
        if (pr0_tag.valid !== 1'b0 || pr1_tag.valid !== 1'b0)
        begin
            $display("ERROR tag valid got %h%h expected 00", pr0_tag.valid, pr1_tag.valid);
            errors++;
        end
        if (hs_s_val !== '0)
        begin
            $display("ERROR hs_s_val got %h expected 00", hs_s_val);
            errors++;
        end
        // everything but the host ack asserted
        acks = ack_count;
        @(posedge clk);
        hs_has_next_angle <= 1'b1;
        pr_next_angle <= 1'b1;
        repeat (12) @(posedge clk);
        pr_next_angle <= 1'b0;
        @(negedge clk);
        if (ack_count != acks)
        begin
            $display("buffers rotated in ready without a host ack");
            errors++;
        end
        close_test("reset", e);
    endtask

    task automatic test_first_fill(input bp_pkg::angle_t a);
        int e;
        int acks;
        int walk;
        int n;
        e = errors;
        acks = ack_count;
        host_step(a);
        walk = 0;
        n = 0;
        // addresses must step up by one, then park on 0
        while (!hs_next_angle && n < wait_limit)
        begin
            @(negedge clk);
            n++;
            if (int'(hs_s_val) == walk + 1)
                walk++;
            else if (int'(hs_s_val) != walk && !(walk == fill_length - 1 && hs_s_val == '0))
            begin
                $display("ERROR hs_s_val got %h expected %h", hs_s_val, walk + 1);
                errors++;
            end
        end
        if (!hs_next_angle || walk != fill_length - 1)
        begin
            $display("fill stopped at address %0d without a next-angle request", walk);
            errors++;
        end
        if (ack_count != acks + 1)
        begin
            $display("expected one pr_next_angle_ack pulse, saw %0d", ack_count - acks);
            errors++;
        end
        close_test("first_fill", e);
    endtask

    task automatic test_steady(input int n);
        int e;
        e = errors;
        for (int i = 0; i < n; i++)
        begin
            advance(bp_pkg::angle_t'($urandom));
            read_check(10);
        end
        close_test("steady", e);
    endtask

    task automatic test_backpressure(input bp_pkg::angle_t a);
        int e;
        int acks;
        bp_pkg::angle_tag_t t0;
        bp_pkg::angle_tag_t t1;
        bp_pkg::fval_t v0;
        bp_pkg::fval_t v1;
        bp_pkg::fval_t w0;
        bp_pkg::fval_t w1;
        e = errors;
        @(posedge clk);
        pr_next_angle <= 1'b1;
        wait_request();
        // host holds its ack low
        present_angle(a);
        acks = ack_count;
        t0 = pr0_tag;
        t1 = pr1_tag;
        read_pair(8'h17, 8'hc4, v0, v1);
        repeat (16) @(posedge clk);
        // now the consumers stall instead
        pr_next_angle <= 1'b0;
        hs_next_angle_ack <= 1'b1;
        repeat (16) @(posedge clk);
        read_pair(8'h17, 8'hc4, w0, w1);
        if (ack_count != acks)
        begin
            $display("buffers rotated while held off");
            errors++;
        end
        if (pr0_tag !== t0)
        begin
            $display("ERROR pr0_tag got %h expected %h", pr0_tag, t0);
            errors++;
        end
        if (pr1_tag !== t1)
        begin
            $display("ERROR pr1_tag got %h expected %h", pr1_tag, t1);
            errors++;
        end
        if (w0 !== v0 || w1 !== v1)
        begin
            $display("ERROR pr0_val/pr1_val got %h/%h expected %h/%h", w0, w1, v0, v1);
            errors++;
        end
        @(posedge clk);
        pr_next_angle <= 1'b1;
        wait_rotate();
        read_check(8);
        close_test("backpressure", e);
    endtask

    task automatic test_drain(input bp_pkg::angle_t a, input bp_pkg::angle_t b);
        int e;
        int acks;
        e = errors;
        // host out of angles
        @(posedge clk);
        hs_has_next_angle <= 1'b0;
        pr_next_angle <= 1'b1;
        wait_rotate();
        read_check(8);
        @(posedge clk);
        pr_next_angle <= 1'b1;
        wait_rotate();
        read_check(8);
        // consumers finish the last angle, idle refill runs out meanwhile
        repeat (fill_length + fill_delay + 8) @(posedge clk);
        pr_done <= 1'b1;
        @(posedge clk);
        pr_done <= 1'b0;
        acks = ack_count;
        repeat (8) @(posedge clk);
        @(negedge clk);
        if (ack_count != acks)
        begin
            $display("buffers rotated after pr_done without a host ack");
            errors++;
        end
        // fresh start from ready
        host_step(a);
        wait_request();
        host_step(b);
        read_check(10);
        close_test("drain", e);
    endtask

    initial
    begin
        rng_init = $urandom(32'had6d31c5);
        errors = 0;
        tests = 0;
        failed_tests = 0;
        ack_count = 0;
        exp_slot = '0;
        exp_pr0 = '0;
        exp_pr1 = '0;
        reset_n = 1'b1;
        hs_angle = '0;
        hs_has_next_angle = 1'b0;
        hs_next_angle_ack = 1'b0;
        hs_raw = '0;
        pr0_s_val = '0;
        pr1_s_val = '0;
        pr_next_angle = 1'b0;
        pr_done = 1'b0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b0;

        test_reset();
        test_first_fill(bp_pkg::angle_t'($urandom));
        test_steady(6);
        test_backpressure(bp_pkg::angle_t'($urandom));
        test_drain(bp_pkg::angle_t'($urandom), bp_pkg::angle_t'($urandom));

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- tb.f
source/bp_pkg.sv
source/fir_filter.sv
source/filtered_ram_swappable.sv
source/swap_sequencer.sv
source/swap_router.sv
source/filtered_ram_subsystem.sv
sim/tb_filtered_ram.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_filtered_ram
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
PASS_MSG ?= Simulation passed
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from the grep, not from the simulator
sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
